// File: hw/hdmiPkg.sv
//////////////////////////////////////////////////
// shared constants for the hdmi tx core
// import into a module body with hdmiPkg::*
//////////////////////////////////////////////////
`default_nettype none

package hdmiPkg;

	// encoder period, video wins over island
	typedef enum logic [1:0] {
		modeControl = 2'd0,
		modeVideo   = 2'd1,
		modeIsland  = 2'd2
	} encMode_t;

	// bch feedback taps, shared by header and subpackets
	localparam logic [7:0] BCH_PATTERN = 8'b10000011;

	// header byte 0 packet types
	localparam logic [7:0] PKT_NULL         = 8'h00;
	localparam logic [7:0] PKT_AUDIO_SAMPLE = 8'h02;

	//////////////////////////////////////////////////
	// symbol tables, bit 9 is sent last
	//////////////////////////////////////////////////

	// control tokens, index {c1,c0}
	localparam logic [9:0] CTRL_TOKEN [0:3] = '{
		10'b1101010100,
		10'b0010101011,
		10'b0101010100,
		10'b1010101011
	};

	// terc4 data island symbols
	localparam logic [9:0] TERC4_TABLE [0:15] = '{
		10'b1010011100, 10'b1001100011, 10'b1011100100, 10'b1011100010,
		10'b0101110001, 10'b0100011110, 10'b0110001110, 10'b0100111100,
		10'b1011001100, 10'b0100111001, 10'b0110011100, 10'b1011000110,
		10'b1010001110, 10'b1001110001, 10'b0101100011, 10'b1011000011
	};

endpackage

`default_nettype wire

// File: hw/audioSampleIntake.sv
//////////////////////////////////////////////////
// audio sample buffer with credit return
// source starts with sampleDepth credits, one back per pop
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module audioSampleIntake #(
	parameter int sampleDepth = 4
) (
	input  wire                               pixclk_global,
	input  wire                               rst,
	input  wire                               sampleValid,
	input  wire  [31:0]                       sampleData,
	output logic                              sampleCredit,
	output logic [$clog2(sampleDepth + 1)-1:0] bufCount,
	input  wire                               popSample,
	output logic [31:0]                       popData
);

	localparam int PTR_W = (sampleDepth > 1) ? $clog2(sampleDepth) : 1;
	localparam int CNT_W = $clog2(sampleDepth + 1);

	logic [31:0]      mem [sampleDepth]; // stereo samples, left in [31:16]
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;

	// wrap at depth, depth need not be a power of two
	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(sampleDepth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////

	always_ff @(posedge pixclk_global) begin
		if (sampleValid) begin
			mem[wrPtr] <= sampleData; // credits keep this from overrunning
		end
	end

	assign popData = mem[rdPtr]; // head of buffer, no read latency

	//////////////////////////////////////////////////
	// pointers, fill level, credits
	//////////////////////////////////////////////////

	always_ff @(posedge pixclk_global) begin
		if (rst) begin
			wrPtr        <= '0;
			rdPtr        <= '0;
			bufCount     <= '0;
			sampleCredit <= 1'b0;
		end else begin
			if (sampleValid) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (popSample) begin
				rdPtr <= nextPtr(rdPtr);
			end
			// push and pop may land on the same cycle
			bufCount     <= bufCount + CNT_W'(sampleValid) - CNT_W'(popSample);
			sampleCredit <= popSample; // credit goes back one cycle after the pop
		end
	end

endmodule

`default_nettype wire

// File: hw/bchShifter.sv
//////////////////////////////////////////////////
// bit serial bch parity for one data island lane
// passes data while passData, then shifts out parity
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module bchShifter (
	input  wire        pixclk_global,
	input  wire        rst,
	input  wire        clear,    // start of a new packet
	input  wire        dualBit,  // two bits per clock, subpacket lanes
	input  wire        passData,
	input  wire  [1:0] dataBits, // bit 0 goes first
	output logic [1:0] outBits
);

	import hdmiPkg::*;

	logic [7:0] parity;
	logic [7:0] step1; // after first bit
	logic [7:0] step2; // after second bit

	// one lfsr step, no feedback once data is done
	function automatic logic [7:0] bchStep(input logic [7:0] p, input logic b, input logic en);
		return (p >> 1) ^ (((p[0] ^ b) && en) ? BCH_PATTERN : 8'h00);
	endfunction

	assign step1 = bchStep(parity, dataBits[0], passData);
	assign step2 = bchStep(step1, dataBits[1], passData);

	always_comb begin
		if (passData) begin
			outBits = dualBit ? dataBits : {1'b0, dataBits[0]};
		end else begin
			outBits = dualBit ? parity[1:0] : {1'b0, parity[0]}; // parity lsb first
		end
	end

	always_ff @(posedge pixclk_global) begin
		if (rst || clear) begin
			parity <= '0;
		end else begin
			parity <= dualBit ? step2 : step1;
		end
	end

endmodule

`default_nettype wire

// File: hw/dataIslandBuilder.sv
//////////////////////////////////////////////////
// one data island packet per line, audio or null
// pops up to four samples just before the island
// and streams header and subpackets as terc4 nibbles
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dataIslandBuilder #(
	parameter int islandStart = 752,
	parameter int sampleDepth = 4
) (
	input  wire                                pixclk_global,
	input  wire                                rst,
	input  wire  [11:0]                        counterX,
	input  wire                                hSync,
	input  wire                                vSync,
	input  wire  [$clog2(sampleDepth + 1)-1:0] bufCount,
	output logic                               popSample,
	input  wire  [31:0]                        popData,
	output logic                               islandActive,
	output logic [3:0]                         nibbleCh0,
	output logic [3:0]                         nibbleCh1,
	output logic [3:0]                         nibbleCh2
);

	import hdmiPkg::*;

	localparam logic [11:0] WIN_FIRST = 12'(islandStart - 4); // first pop slot
	localparam logic [11:0] PREP_X    = 12'(islandStart - 1); // last pop, latch

	logic        inWindow;
	logic        prepCycle;
	logic [2:0]  popCnt;     // samples taken so far this window
	logic [1:0]  slot;
	logic [2:0]  sampleCnt;
	logic [3:0]  present;
	logic [23:0] hdrShift;   // hb0 goes first
	logic [55:0] subShift [4];
	logic [4:0]  pos;        // island cycle 0..31
	logic        hdrPass;
	logic        subPass;
	logic [1:0]  hdrBits;
	logic [1:0]  subBits [4];

	// one audio subpacket, v u c bits left at zero
	function automatic logic [55:0] packSample(input logic [31:0] s);
		logic [55:0] sp;
		sp        = '0;
		sp[23:8]  = s[31:16];  // left
		sp[47:32] = s[15:0];   // right
		sp[51]    = ^s[31:16]; // even parity, left
		sp[55]    = ^s[15:0];  // even parity, right
		return sp;
	endfunction

	//////////////////////////////////////////////////
	// sample collection and packet prep
	//////////////////////////////////////////////////

	assign inWindow  = (counterX >= WIN_FIRST) && (counterX <= PREP_X);
	assign prepCycle = (counterX == PREP_X);
	assign popSample = inWindow && (bufCount != '0); // one per cycle, four max
	assign slot      = (counterX == WIN_FIRST) ? 2'd0 : popCnt[1:0];
	assign sampleCnt = popCnt + 3'(popSample); // includes the pop on prep
	assign present   = 4'((5'd1 << sampleCnt) - 5'd1);

	always_ff @(posedge pixclk_global) begin
		if (rst) begin
			popCnt       <= '0;
			islandActive <= 1'b0;
			pos          <= '0;
		end else begin
			if (inWindow) begin
				popCnt <= ((counterX == WIN_FIRST) ? 3'd0 : popCnt) + 3'(popSample);
			end
			if (prepCycle) begin
				islandActive <= 1'b1;
				pos          <= '0;
			end else if (islandActive) begin
				pos <= pos + 1'b1;
				if (pos == 5'd31) begin
					islandActive <= 1'b0; // 32 cycles done
				end
			end
		end
	end

	always_ff @(posedge pixclk_global) begin
		if (counterX == WIN_FIRST) begin
			for (int k = 0; k < 4; k++) begin
				subShift[k] <= '0; // unused subpackets stay zero
			end
		end
		if (popSample) begin
			subShift[slot] <= packSample(popData);
		end
		if (prepCycle) begin
			// hb2 zero, hb1 = layout 0 + sample_present, hb0 = type
			hdrShift <= {8'h00, 4'h0, present,
				(sampleCnt != 3'd0) ? PKT_AUDIO_SAMPLE : PKT_NULL};
		end
		if (islandActive) begin
			hdrShift <= hdrShift >> 1;
			for (int k = 0; k < 4; k++) begin
				subShift[k] <= subShift[k] >> 2;
			end
		end
	end

	//////////////////////////////////////////////////
	// bch lanes
	//////////////////////////////////////////////////

	assign hdrPass = (pos < 5'd24); // 24 header bits then 8 parity
	assign subPass = (pos < 5'd28); // 56 subpacket bits then 8 parity

	bchShifter uHdrBch (
		.pixclk_global (pixclk_global),
		.rst           (rst),
		.clear         (prepCycle),
		.dualBit       (1'b0),
		.passData      (hdrPass),
		.dataBits      ({1'b0, hdrShift[0]}),
		.outBits       (hdrBits)
	);

	for (genvar g = 0; g < 4; g++) begin : gSub
		bchShifter uSubBch (
			.pixclk_global (pixclk_global),
			.rst           (rst),
			.clear         (prepCycle),
			.dualBit       (1'b1),
			.passData      (subPass),
			.dataBits      (subShift[g][1:0]),
			.outBits       (subBits[g])
		);
		assign nibbleCh1[g] = subBits[g][0]; // even bits
		assign nibbleCh2[g] = subBits[g][1]; // odd bits
	end

	// ch0 carries sync, first cycle marker and the header bit
	assign nibbleCh0 = {hdrBits[0], (pos != 5'd0), vSync, hSync};

endmodule

`default_nettype wire

// File: hw/tmdsChannelEncoder.sv
//////////////////////////////////////////////////
// tmds encoder for one channel, 1 cycle latency
// video 8b/10b, control tokens or terc4 island data
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tmdsChannelEncoder (
	input  wire        pixclk_global,
	input  wire        rst,
	input  wire  [7:0] pixel,
	input  wire        c0,
	input  wire        c1,
	input  wire        drawArea,
	input  wire        islandActive,
	input  wire  [3:0] islandNibble,
	output logic [9:0] symbolOut
);

	import hdmiPkg::*;

	encMode_t          mode;
	logic [3:0]        onesIn;
	logic [3:0]        onesQm;
	logic              useXnor;
	logic [8:0]        qm;        // transition minimised word
	logic signed [4:0] diffQm;    // ones minus zeros of qm[7:0]
	logic signed [4:0] disparity; // running dc balance
	logic signed [4:0] dispNext;
	logic [9:0]        vidSym;

	// video first, island only in blanking
	always_comb begin
		if (drawArea) begin
			mode = modeVideo;
		end else if (islandActive) begin
			mode = modeIsland;
		end else begin
			mode = modeControl;
		end
	end

	//////////////////////////////////////////////////
	// 8b/10b video path
	//////////////////////////////////////////////////

	always_comb begin
		onesIn = '0;
		for (int i = 0; i < 8; i++) begin
			onesIn = onesIn + 4'(pixel[i]);
		end
		useXnor = (onesIn > 4'd4) || ((onesIn == 4'd4) && !pixel[0]);
		qm[0] = pixel[0];
		for (int i = 1; i < 8; i++) begin
			qm[i] = useXnor ? ~(qm[i-1] ^ pixel[i]) : (qm[i-1] ^ pixel[i]);
		end
		qm[8] = ~useXnor;
		onesQm = '0;
		for (int i = 0; i < 8; i++) begin
			onesQm = onesQm + 4'(qm[i]);
		end
		diffQm = 5'(onesQm) - 5'(4'd8 - onesQm);

		if ((disparity == 0) || (diffQm == 0)) begin
			vidSym   = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
			dispNext = qm[8] ? (disparity + diffQm) : (disparity - diffQm);
		end else if (((disparity > 0) && (diffQm > 0)) || ((disparity < 0) && (diffQm < 0))) begin
			vidSym   = {1'b1, qm[8], ~qm[7:0]}; // invert to pull back toward zero
			dispNext = disparity + 5'({qm[8], 1'b0}) - diffQm;
		end else begin
			vidSym   = {1'b0, qm[8], qm[7:0]};
			dispNext = disparity - 5'({~qm[8], 1'b0}) + diffQm;
		end
	end

	//////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////

	always_ff @(posedge pixclk_global) begin
		if (rst) begin
			symbolOut <= CTRL_TOKEN[{c1, c0}];
			disparity <= '0;
		end else begin
			case (mode)
				modeVideo: begin
					symbolOut <= vidSym;
					disparity <= dispNext;
				end
				modeIsland: begin
					symbolOut <= TERC4_TABLE[islandNibble];
					disparity <= '0; // balance restarts each active period
				end
				default: begin
					symbolOut <= CTRL_TOKEN[{c1, c0}];
					disparity <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/hdmiTx.sv
//////////////////////////////////////////////////
// hdmi tx top, pixel clock domain only
// symbols follow their inputs by one clock
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hdmiTx #(
	parameter int islandStart = 752, // first island pixel
	parameter int sampleDepth = 4    // buffer depth = initial credits
) (
	input  wire         pixclk_global,
	input  wire         rst,
	input  wire  [7:0]  red,
	input  wire  [7:0]  green,
	input  wire  [7:0]  blue,
	input  wire         hSync,
	input  wire         vSync,
	input  wire         drawArea,
	input  wire  [11:0] counterX,
	input  wire         sampleValid,
	input  wire  [31:0] sampleData,
	output logic        sampleCredit,
	output logic [9:0]  symbolR,
	output logic [9:0]  symbolG,
	output logic [9:0]  symbolB
);

	localparam int CNT_W = $clog2(sampleDepth + 1);

	logic [CNT_W-1:0] bufCount;
	logic             popSample;
	logic [31:0]      popData;
	logic             islandActive;
	logic [3:0]       nibbleCh0;
	logic [3:0]       nibbleCh1;
	logic [3:0]       nibbleCh2;

	audioSampleIntake #(.sampleDepth(sampleDepth)) uIntake (
		.pixclk_global (pixclk_global),
		.rst           (rst),
		.sampleValid   (sampleValid),
		.sampleData    (sampleData),
		.sampleCredit  (sampleCredit),
		.bufCount      (bufCount),
		.popSample     (popSample),
		.popData       (popData)
	);

	dataIslandBuilder #(
		.islandStart (islandStart),
		.sampleDepth (sampleDepth)
	) uBuilder (
		.pixclk_global (pixclk_global),
		.rst           (rst),
		.counterX      (counterX),
		.hSync         (hSync),
		.vSync         (vSync),
		.bufCount      (bufCount),
		.popSample     (popSample),
		.popData       (popData),
		.islandActive  (islandActive),
		.nibbleCh0     (nibbleCh0),
		.nibbleCh1     (nibbleCh1),
		.nibbleCh2     (nibbleCh2)
	);

	// channel 0, sync rides on c0/c1
	tmdsChannelEncoder uEncB (
		.pixclk_global (pixclk_global),
		.rst           (rst),
		.pixel         (blue),
		.c0            (hSync),
		.c1            (vSync),
		.drawArea      (drawArea),
		.islandActive  (islandActive),
		.islandNibble  (nibbleCh0),
		.symbolOut     (symbolB)
	);

	tmdsChannelEncoder uEncG ( // channel 1
		.pixclk_global (pixclk_global),
		.rst           (rst),
		.pixel         (green),
		.c0            (1'b0),
		.c1            (1'b0),
		.drawArea      (drawArea),
		.islandActive  (islandActive),
		.islandNibble  (nibbleCh1),
		.symbolOut     (symbolG)
	);

	tmdsChannelEncoder uEncR ( // channel 2
		.pixclk_global (pixclk_global),
		.rst           (rst),
		.pixel         (red),
		.c0            (1'b0),
		.c1            (1'b0),
		.drawArea      (drawArea),
		.islandActive  (islandActive),
		.islandNibble  (nibbleCh2),
		.symbolOut     (symbolR)
	);

endmodule

`default_nettype wire

// File: tb/tbRefModel.svh
//////////////////////////////////////////////////
// reference model for the hdmi tx testbench
// include inside the testbench module, after hdmiPkg import
//////////////////////////////////////////////////
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam logic [7:0] BCH_GEN = 8'b10000011; // x^8 + x^7 + x^6 + 1, lsb first form

// dvi 8b/10b, running disparity in and out
function automatic logic [9:0] videoSymbol(input logic [7:0] d, input int dispIn,
		output int dispOut);
	int         n1d;
	int         n1;
	logic       xnorSel;
	logic [8:0] q;
	n1d = 0;
	for (int i = 0; i < 8; i++) begin
		n1d += d[i];
	end
	xnorSel = (n1d > 4) || ((n1d == 4) && (d[0] == 1'b0));
	q[0] = d[0];
	for (int i = 1; i < 8; i++) begin
		q[i] = xnorSel ? (q[i-1] ~^ d[i]) : (q[i-1] ^ d[i]);
	end
	q[8] = !xnorSel;
	n1 = 0;
	for (int i = 0; i < 8; i++) begin
		n1 += q[i];
	end
	if ((dispIn == 0) || (n1 == 4)) begin // no bias either way
		dispOut = q[8] ? (dispIn + 2 * n1 - 8) : (dispIn + 8 - 2 * n1);
		return {!q[8], q[8], q[8] ? q[7:0] : ~q[7:0]};
	end
	if (((dispIn > 0) && (n1 > 4)) || ((dispIn < 0) && (n1 < 4))) begin
		dispOut = dispIn + 2 * q[8] + 8 - 2 * n1;
		return {1'b1, q[8], ~q[7:0]};
	end
	dispOut = dispIn - 2 * (!q[8]) + 2 * n1 - 8;
	return {1'b0, q[8], q[7:0]};
endfunction

// terc4 island symbols, bit 9 sent last
function automatic logic [9:0] terc4Symbol(input logic [3:0] n);
	case (n)
		4'h0: return 10'b1010011100;
		4'h1: return 10'b1001100011;
		4'h2: return 10'b1011100100;
		4'h3: return 10'b1011100010;
		4'h4: return 10'b0101110001;
		4'h5: return 10'b0100011110;
		4'h6: return 10'b0110001110;
		4'h7: return 10'b0100111100;
		4'h8: return 10'b1011001100;
		4'h9: return 10'b0100111001;
		4'ha: return 10'b0110011100;
		4'hb: return 10'b1011000110;
		4'hc: return 10'b1010001110;
		4'hd: return 10'b1001110001;
		4'he: return 10'b0101100011;
		default: return 10'b1011000011;
	endcase
endfunction

// control period tokens, index {c1,c0}
function automatic logic [9:0] ctrlSymbol(input logic [1:0] c);
	case (c)
		2'd0: return 10'b1101010100;
		2'd1: return 10'b0010101011;
		2'd2: return 10'b0101010100;
		default: return 10'b1010101011;
	endcase
endfunction

// bch parity over the first nBits, bit 0 first
function automatic logic [7:0] bchParity(input logic [63:0] data, input int nBits);
	logic [7:0] p;
	p = '0;
	for (int i = 0; i < nBits; i++) begin
		p = (p >> 1) ^ ((p[0] ^ data[i]) ? BCH_GEN : 8'h00);
	end
	return p;
endfunction

// audio subpacket, parity byte on top
function automatic logic [63:0] subCodeword(input logic [31:0] s);
	logic [55:0] sp;
	sp        = '0;
	sp[23:8]  = s[31:16]; // left channel
	sp[47:32] = s[15:0];  // right channel
	sp[51]    = ^s[31:16];
	sp[55]    = ^s[15:0];
	return {bchParity(sp, 56), sp};
endfunction

// header hb0..hb2 then parity, n samples present
function automatic logic [31:0] hdrCodeword(input int n);
	logic [3:0]  present;
	logic [23:0] hb;
	present = (1 << n) - 1;
	hb      = {8'h00, 4'h0, present, (n > 0) ? PKT_AUDIO_SAMPLE : PKT_NULL};
	return {bchParity(hb, 24), hb};
endfunction

`endif

// File: tb/tbHdmiTx.sv
//////////////////////////////////////////////////
// testbench for the hdmi tx core
// drives video lines and credited audio and checks all symbols
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tbHdmiTx;

	import hdmiPkg::*;

	localparam int ISLAND_X    = 752;
	localparam int DEPTH       = 4;
	localparam int LINE_LEN    = 900;
	localparam int ACTIVE_W    = 640;
	localparam int NUM_LINES   = 40;
	localparam int SEND_LAST   = 700; // source goes quiet here before the pop window
	localparam int CYCLE_LIMIT = NUM_LINES * LINE_LEN + 3 + 500;

	`include "tbRefModel.svh"

	logic        pixclk_global = 1'b0;
	logic        rst;
	logic [7:0]  red;
	logic [7:0]  green;
	logic [7:0]  blue;
	logic        hSync;
	logic        vSync;
	logic        drawArea;
	logic [11:0] counterX;
	logic        sampleValid;
	logic [31:0] sampleData;
	wire         sampleCredit;
	wire  [9:0]  symbolR;
	wire  [9:0]  symbolG;
	wire  [9:0]  symbolB;

	int          seed;
	int          errors = 0;
	int          cycles = 0;
	int          credits;      // source side credit count
	int          sentTotal = 0;
	int          creditPulses = 0;
	int          packedTotal = 0;
	int          lineNo;
	logic [31:0] pendQ [$];    // sent but not yet packed
	logic [31:0] hdrCw = '0;
	logic [63:0] subCw [4];
	int          dispB = 0;
	int          dispG = 0;
	int          dispR = 0;
	logic [9:0]  expR;
	logic [9:0]  expG;
	logic [9:0]  expB;

	hdmiTx #(.islandStart(ISLAND_X), .sampleDepth(DEPTH)) hdmiTx_inst (
		.pixclk_global (pixclk_global),
		.rst           (rst),
		.red           (red),
		.green         (green),
		.blue          (blue),
		.hSync         (hSync),
		.vSync         (vSync),
		.drawArea      (drawArea),
		.counterX      (counterX),
		.sampleValid   (sampleValid),
		.sampleData    (sampleData),
		.sampleCredit  (sampleCredit),
		.symbolR       (symbolR),
		.symbolG       (symbolG),
		.symbolB       (symbolB)
	);

	initial begin
		forever begin
			#2 pixclk_global = ~pixclk_global; // 4 ns period
		end
	end

	always @(posedge pixclk_global) begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the line sequence never finished", cycles);
			$display("test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// expected symbols from inputs stable at this edge
	//////////////////////////////////////////////////

	always @(posedge pixclk_global) begin : expectModel
		int         k;
		int         n;
		logic [3:0] nib1;
		logic [3:0] nib2;
		k = counterX - ISLAND_X; // island cycle or negative before it
		if (drawArea) begin
			expB = videoSymbol(blue, dispB, dispB);
			expG = videoSymbol(green, dispG, dispG);
			expR = videoSymbol(red, dispR, dispR);
		end else if ((k >= 0) && (k < 32)) begin
			for (int g = 0; g < 4; g++) begin
				nib1[g] = subCw[g][2 * k];     // even bit of subpacket g
				nib2[g] = subCw[g][2 * k + 1];
			end
			expB  = terc4Symbol({hdrCw[k], k != 0, vSync, hSync});
			expG  = terc4Symbol(nib1);
			expR  = terc4Symbol(nib2);
			dispB = 0;
			dispG = 0;
			dispR = 0;
		end else begin
			expB  = ctrlSymbol({vSync, hSync});
			expG  = ctrlSymbol(2'b00);
			expR  = ctrlSymbol(2'b00);
			dispB = 0; // balance restarts with the next active period
			dispG = 0;
			dispR = 0;
		end
		if (!rst && (counterX == ISLAND_X - 1)) begin // packet for the coming island
			n     = (pendQ.size() < 4) ? pendQ.size() : 4;
			hdrCw = hdrCodeword(n);
			for (int g = 0; g < 4; g++) begin
				subCw[g] = (g < n) ? subCodeword(pendQ.pop_front()) : 64'h0;
			end
			packedTotal += n;
		end
	end

	task automatic compareSymbol(input string chName, input logic [9:0] got,
			input logic [9:0] want);
		if (got !== want) begin
			errors++;
			$display("Mismatch at %0t: %s symbol %b, expected %b", $time, chName, got, want);
		end
	endtask

	// symbols settle after the rising edge
	always @(negedge pixclk_global) begin
		compareSymbol("blue", symbolB, expB);
		compareSymbol("green", symbolG, expG);
		compareSymbol("red", symbolR, expR);
		if (rst && (sampleCredit !== 1'b0)) begin
			errors++;
			$display("Mismatch at %0t: sampleCredit high during reset", $time);
		end
	end

	//////////////////////////////////////////////////
	// stimulus driven on the falling edge
	//////////////////////////////////////////////////

	task automatic driveInputs(input int x);
		if (sampleCredit) begin
			credits++;
			creditPulses++;
		end
		if (credits > DEPTH) begin
			errors++;
			$display("credit count went above the buffer depth at %0t", $time);
		end
		counterX = x;
		drawArea = (x < ACTIVE_W);
		hSync    = (x >= 760) && (x < 860); // overlaps the island
		vSync    = (lineNo % 8) < 2;
		red      = $random(seed);
		green    = $random(seed);
		blue     = $random(seed);
		sampleValid = 1'b0;
		// every fourth line idle and the last two lines drain
		if ((lineNo < NUM_LINES - 2) && (lineNo % 4 != 3) && (x < SEND_LAST) && (credits > 0)
				&& (($random(seed) & 255) == 0)) begin
			sampleValid = 1'b1;
			sampleData  = $random(seed);
			credits--;
			sentTotal++;
			pendQ.push_back(sampleData);
		end
	endtask

	initial begin
		seed        = 32'he338;
		rst         = 1'b1;
		red         = '0;
		green       = '0;
		blue        = '0;
		hSync       = 1'b0;
		vSync       = 1'b0;
		drawArea    = 1'b0;
		counterX    = '0;
		sampleValid = 1'b0;
		sampleData  = '0;
		credits     = DEPTH;
		lineNo      = 0;
		repeat (3) @(negedge pixclk_global);
		rst = 1'b0;
		for (lineNo = 0; lineNo < NUM_LINES; lineNo++) begin
			for (int x = 0; x < LINE_LEN; x++) begin
				driveInputs(x);
				@(negedge pixclk_global);
			end
		end
		@(negedge pixclk_global); // last symbols compared
		if (pendQ.size() != 0) begin
			errors++;
			$display("%0d sent samples never showed up in a packet", pendQ.size());
		end
		if (creditPulses != packedTotal) begin
			errors++;
			$display("Mismatch at %0t: %0d credit pulses, %0d samples packed", $time,
				creditPulses, packedTotal);
		end
		if (packedTotal != sentTotal) begin
			errors++;
			$display("Mismatch at %0t: %0d samples sent, %0d packed", $time,
				sentTotal, packedTotal);
		end
		$display("errors %0d, samples sent %0d, packed %0d, credit pulses %0d", errors,
			sentTotal, packedTotal, creditPulses);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+tb
hw/hdmiPkg.sv
hw/audioSampleIntake.sv
hw/bchShifter.sv
hw/dataIslandBuilder.sv
hw/tmdsChannelEncoder.sv
hw/hdmiTx.sv
tb/tbHdmiTx.sv

// File: Bender.yml
package:
  name: hdmi_tx

sources:
  - target: rtl
    files:
      - hw/hdmiPkg.sv
      - hw/audioSampleIntake.sv
      - hw/bchShifter.sv
      - hw/dataIslandBuilder.sv
      - hw/tmdsChannelEncoder.sv
      - hw/hdmiTx.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tbHdmiTx.sv
